//--- src/or1200_settings.svh
`ifndef OR1200_SETTINGS_SVH
`define OR1200_SETTINGS_SVH

// Data and address widths
`define OR1200_OPERAND_WIDTH	32
`define OR1200_SPR_ADDR_WIDTH	16

// Group field of an SPR address, the rest is the register index
`define OR1200_SPR_GROUP_MSB	15
`define OR1200_SPR_GROUP_LSB	11

// Group numbers
`define OR1200_SPR_GROUP_PIC	5'd9
`define OR1200_SPR_GROUP_TT	5'd10

// Register indices inside the PIC group
`define OR1200_PIC_OFS_PICMR	11'd0
`define OR1200_PIC_OFS_PICSR	11'd2

// Register indices inside the tick timer group
`define OR1200_TT_OFS_TTMR	11'd0
`define OR1200_TT_OFS_TTCR	11'd1

// Interrupt lines and mask after reset
`define OR1200_PIC_INTS		20
`define OR1200_PIC_PICMR_RESET	32'h00000003

// Period field of TTMR
`define OR1200_TT_PERIOD_WIDTH	28

`endif

//--- src/spr_pkg.sv
package spr_pkg;

	// Register picked for the read data path
	// SEL_NONE covers writes and unknown addresses
	typedef enum logic [2:0] {
		SEL_NONE  = 3'd0,
		SEL_PICMR = 3'd1,
		SEL_PICSR = 3'd2,
		SEL_TTMR  = 3'd3,
		SEL_TTCR  = 3'd4
	} spr_reg_sel_e;

endpackage

//--- src/spr_decode.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module spr_decode import spr_pkg::*; (
	input  logic				spr_stb_i,
	input  logic				spr_we_i,
	input  logic [`OR1200_SPR_ADDR_WIDTH-1:0]	spr_addr_i,
	output logic				picmr_we_o,
	output logic				picsr_we_o,
	output logic				ttmr_we_o,
	output logic				ttcr_we_o,
	output logic				rd_stb_o,
	output spr_reg_sel_e			rd_sel_o
);

	logic [`OR1200_SPR_GROUP_MSB-`OR1200_SPR_GROUP_LSB:0]	grp;
	logic [`OR1200_SPR_GROUP_LSB-1:0]			ofs;
	logic	hit_picmr;
	logic	hit_picsr;
	logic	hit_ttmr;
	logic	hit_ttcr;
	logic	wr;

	// Split address into group and register index
	assign grp = spr_addr_i[`OR1200_SPR_GROUP_MSB:`OR1200_SPR_GROUP_LSB];
	assign ofs = spr_addr_i[`OR1200_SPR_GROUP_LSB-1:0];

	assign hit_picmr = (grp == `OR1200_SPR_GROUP_PIC) && (ofs == `OR1200_PIC_OFS_PICMR);
	assign hit_picsr = (grp == `OR1200_SPR_GROUP_PIC) && (ofs == `OR1200_PIC_OFS_PICSR);
	assign hit_ttmr  = (grp == `OR1200_SPR_GROUP_TT) && (ofs == `OR1200_TT_OFS_TTMR);
	assign hit_ttcr  = (grp == `OR1200_SPR_GROUP_TT) && (ofs == `OR1200_TT_OFS_TTCR);

	// Write enables, at most one per strobed write
	assign wr = spr_stb_i & spr_we_i;

	assign picmr_we_o = wr & hit_picmr;
	assign picsr_we_o = wr & hit_picsr;
	assign ttmr_we_o  = wr & hit_ttmr;
	assign ttcr_we_o  = wr & hit_ttcr;

	// Read path
	assign rd_stb_o = spr_stb_i & ~spr_we_i;

	always_comb begin
		rd_sel_o = SEL_NONE;
		if (hit_picmr)
			rd_sel_o = SEL_PICMR;
		else if (hit_picsr)
			rd_sel_o = SEL_PICSR;
		else if (hit_ttmr)
			rd_sel_o = SEL_TTMR;
		else if (hit_ttcr)
			rd_sel_o = SEL_TTCR;
	end

endmodule

//--- src/pic_unit.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module pic_unit (
	input  logic				clk_i,
	input  logic				rst_n_i,
	input  logic				picmr_we_i,
	input  logic				picsr_we_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	spr_dat_i,
	input  logic [`OR1200_PIC_INTS-1:0]	pic_ints_i,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	picmr_o,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	picsr_o,
	output logic				sig_int_o
);

	localparam int dw = `OR1200_OPERAND_WIDTH;
	localparam int n_ints = `OR1200_PIC_INTS;
	localparam logic [dw-1:0] picmr_reset = `OR1200_PIC_PICMR_RESET;

	// Lines 0 and 1 ignore the mask
	localparam logic [n_ints-1:0] unmaskable = {{(n_ints-2){1'b0}}, 2'b11};

	logic [n_ints-1:0]	picmr;
	logic [n_ints-1:0]	picsr;
	logic [n_ints-1:0]	gathered;

	// Inputs that may set a status bit this cycle
	assign gathered = pic_ints_i & (picmr | unmaskable);

	// Mask register
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			picmr <= picmr_reset[n_ints-1:0];
		else if (picmr_we_i)
			picmr <= spr_dat_i[n_ints-1:0];
	end

	// Sticky status
	// A write cannot clear a bit whose input is still high
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			picsr <= '0;
		else if (picsr_we_i)
			picsr <= spr_dat_i[n_ints-1:0] | gathered;
		else
			picsr <= picsr | gathered;
	end

	assign picmr_o = {{(dw-n_ints){1'b0}}, picmr};
	assign picsr_o = {{(dw-n_ints){1'b0}}, picsr};

	// Any pending status raises the request
	assign sig_int_o = |picsr;

endmodule

//--- src/tick_timer.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module tick_timer (
	input  logic				clk_i,
	input  logic				rst_n_i,
	input  logic				ttmr_we_i,
	input  logic				ttcr_we_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	spr_dat_i,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	ttmr_o,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	ttcr_o,
	output logic				sig_tick_o
);

	localparam int pw = `OR1200_TT_PERIOD_WIDTH;

	// Bit positions above the period field
	localparam int ip_bit = pw;
	localparam int ie_bit = pw + 1;
	localparam int m_lsb  = pw + 2;

	// Counter modes
	localparam logic [1:0] mode_off     = 2'b00;
	localparam logic [1:0] mode_restart = 2'b01;
	localparam logic [1:0] mode_stop    = 2'b10;
	localparam logic [1:0] mode_cont    = 2'b11;

	logic [`OR1200_OPERAND_WIDTH-1:0]	ttmr;
	logic [`OR1200_OPERAND_WIDTH-1:0]	ttcr;
	logic [1:0]		mode;
	logic			ie;
	logic			ip;
	logic [pw-1:0]		period;
	logic			match;

	assign mode   = ttmr[m_lsb+1:m_lsb];
	assign ie     = ttmr[ie_bit];
	assign ip     = ttmr[ip_bit];
	assign period = ttmr[pw-1:0];

	// Only the low period bits of the counter are compared
	assign match = (mode != mode_off) && (ttcr[pw-1:0] == period);

	// Mode register with pending flag
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ttmr <= '0;
		else if (ttmr_we_i)
			ttmr <= spr_dat_i;
		else if (match && ie)
			ttmr[ip_bit] <= 1'b1;
	end

	// Counter
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ttcr <= '0;
		end else if (ttcr_we_i) begin
			ttcr <= spr_dat_i;
		end else begin
			case (mode)
				mode_restart:
					ttcr <= match ? '0 : ttcr + 1'b1;
				mode_stop:
					if (!match)
						ttcr <= ttcr + 1'b1;
				mode_cont:
					ttcr <= ttcr + 1'b1;
				default:
					ttcr <= ttcr;
			endcase
		end
	end

	assign ttmr_o = ttmr;
	assign ttcr_o = ttcr;

	// Tick request while pending and enabled
	assign sig_tick_o = ip & ie;

endmodule

//--- src/spr_result.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module spr_result import spr_pkg::*; (
	input  logic				clk_i,
	input  logic				rst_n_i,
	input  logic				rd_stb_i,
	input  logic				spr_stb_i,
	input  spr_reg_sel_e			rd_sel_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	picmr_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	picsr_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	ttmr_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	ttcr_i,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	spr_dat_o,
	output logic				spr_ack_o
);

	logic [`OR1200_OPERAND_WIDTH-1:0]	rd_dat;

	// Read mux, unknown registers read as zero
	always_comb begin
		case (rd_sel_i)
			SEL_PICMR: rd_dat = picmr_i;
			SEL_PICSR: rd_dat = picsr_i;
			SEL_TTMR:  rd_dat = ttmr_i;
			SEL_TTCR:  rd_dat = ttcr_i;
			default:   rd_dat = '0;
		endcase
	end

	// Data is captured with the strobe and held until the next access
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			spr_dat_o <= '0;
		end else if (spr_stb_i) begin
			spr_dat_o <= rd_stb_i ? rd_dat : '0;
		end
	end

	// One ack per strobe, one cycle later
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			spr_ack_o <= 1'b0;
		else
			spr_ack_o <= spr_stb_i;
	end

endmodule

//--- src/or1200_spr_periph_top.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module or1200_spr_periph_top import spr_pkg::*; (
	input  logic				clk_i,
	input  logic				rst_n_i,
	// SPR bus
	input  logic				spr_stb_i,
	input  logic				spr_we_i,
	input  logic [`OR1200_SPR_ADDR_WIDTH-1:0]	spr_addr_i,
	input  logic [`OR1200_OPERAND_WIDTH-1:0]	spr_dat_i,
	output logic [`OR1200_OPERAND_WIDTH-1:0]	spr_dat_o,
	output logic				spr_ack_o,
	// Interrupt sources and requests
	input  logic [`OR1200_PIC_INTS-1:0]	pic_ints_i,
	output logic				sig_int_o,
	output logic				sig_tick_o
);

	// Decode to units
	logic		picmr_we;
	logic		picsr_we;
	logic		ttmr_we;
	logic		ttcr_we;

	// Decode to result stage
	logic		rd_stb;
	spr_reg_sel_e	rd_sel;

	// Register contents for readback
	logic [`OR1200_OPERAND_WIDTH-1:0]	picmr;
	logic [`OR1200_OPERAND_WIDTH-1:0]	picsr;
	logic [`OR1200_OPERAND_WIDTH-1:0]	ttmr;
	logic [`OR1200_OPERAND_WIDTH-1:0]	ttcr;

	spr_decode spr_decode (
		.spr_stb_i	(spr_stb_i),
		.spr_we_i	(spr_we_i),
		.spr_addr_i	(spr_addr_i),
		.picmr_we_o	(picmr_we),
		.picsr_we_o	(picsr_we),
		.ttmr_we_o	(ttmr_we),
		.ttcr_we_o	(ttcr_we),
		.rd_stb_o	(rd_stb),
		.rd_sel_o	(rd_sel)
	);

	// Programmable interrupt controller
	pic_unit pic_unit (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.picmr_we_i	(picmr_we),
		.picsr_we_i	(picsr_we),
		.spr_dat_i	(spr_dat_i),
		.pic_ints_i	(pic_ints_i),
		.picmr_o	(picmr),
		.picsr_o	(picsr),
		.sig_int_o	(sig_int_o)
	);

	// Tick timer
	tick_timer tick_timer (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.ttmr_we_i	(ttmr_we),
		.ttcr_we_i	(ttcr_we),
		.spr_dat_i	(spr_dat_i),
		.ttmr_o		(ttmr),
		.ttcr_o		(ttcr),
		.sig_tick_o	(sig_tick_o)
	);

	spr_result spr_result (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.rd_stb_i	(rd_stb),
		.spr_stb_i	(spr_stb_i),
		.rd_sel_i	(rd_sel),
		.picmr_i	(picmr),
		.picsr_i	(picsr),
		.ttmr_i		(ttmr),
		.ttcr_i		(ttcr),
		.spr_dat_o	(spr_dat_o),
		.spr_ack_o	(spr_ack_o)
	);

endmodule

//--- testbench/tb_spr_cases.svh
`ifndef TB_SPR_CASES_SVH
`define TB_SPR_CASES_SVH

// Columns are name, operation, address, data and expected read or line level
// Wait entries carry the line in the address and the cycle bound in the data

task automatic load_cases();
	// Readback of random values with the counter held in mode 0
	add_case("picmr_wr",      op_write, addr_picmr, rnd_picmr,    32'h0);
	add_case("ttmr_wr",       op_write, addr_ttmr,  rnd_ttmr,     32'h0);
	add_case("ttcr_wr",       op_write, addr_ttcr,  rnd_ttcr,     32'h0);
	add_case("picmr_rd",      op_read,  addr_picmr, 32'h0,        rnd_picmr & 32'h000f_ffff);
	add_case("ttmr_rd",       op_read,  addr_ttmr,  32'h0,        rnd_ttmr);
	add_case("ttcr_rd",       op_read,  addr_ttcr,  32'h0,        rnd_ttcr);

	// Unknown addresses read zero and ignore writes
	add_case("bad_group_rd",  op_read,  16'h1234,   32'h0,        32'h0);
	add_case("ttmr_rd_again", op_read,  addr_ttmr,  32'h0,        rnd_ttmr);
	add_case("bad_pic_rd",    op_read,  16'h4801,   32'h0,        32'h0);
	add_case("bad_tt_wr",     op_write, 16'h5002,   32'hffff_ffff, 32'h0);
	add_case("ttcr_rd_again", op_read,  addr_ttcr,  32'h0,        rnd_ttcr);

	// Line 5 enabled with lines 0, 5 and 7 driven
	add_case("picmr_line5",   op_write, addr_picmr, 32'h0000_0020, 32'h0);
	add_case("ints_on",       op_ints,  16'h0,      32'h0000_00a1, 32'h0);
	add_case("int_high",      op_wait,  line_int,   32'd2,        32'd1);
	add_case("picsr_rd",      op_read,  addr_picsr, 32'h0,        32'h0000_0021);

	// Status stays set after the inputs drop until zero is written
	add_case("ints_off",      op_ints,  16'h0,      32'h0,        32'h0);
	add_case("picsr_rd_held", op_read,  addr_picsr, 32'h0,        32'h0000_0021);
	add_case("picsr_clr",     op_write, addr_picsr, 32'h0,        32'h0);
	add_case("int_low",       op_wait,  line_int,   32'd2,        32'd0);
	add_case("picsr_rd_zero", op_read,  addr_picsr, 32'h0,        32'h0);

	// Restart mode with period 20 and the interrupt enabled
	add_case("ttcr_zero",     op_write, addr_ttcr,  32'h0,        32'h0);
	add_case("ttmr_restart",  op_write, addr_ttmr,  32'h6000_0014, 32'h0);
	add_case("tick_restart",  op_wait,  line_tick,  32'd25,       32'd1);
	add_case("ttmr_ip_clr",   op_write, addr_ttmr,  32'h6000_0014, 32'h0);
	add_case("tick_cleared",  op_wait,  line_tick,  32'd2,        32'd0);

	// Stop mode with period 10 where the counter parks on the match
	add_case("ttmr_off",      op_write, addr_ttmr,  32'h0,        32'h0);
	add_case("ttcr_zero_b",   op_write, addr_ttcr,  32'h0,        32'h0);
	add_case("ttmr_stop",     op_write, addr_ttmr,  32'ha000_000a, 32'h0);
	add_case("tick_stop",     op_wait,  line_tick,  32'd15,       32'd1);
	add_case("ttcr_rd_a",     op_read,  addr_ttcr,  32'h0,        32'd10);
	add_case("gap",           op_idle,  16'h0,      32'd3,        32'h0);
	add_case("ttcr_rd_b",     op_read,  addr_ttcr,  32'h0,        32'd10);
	// Pending flag now set on top of the written mode
	add_case("ttmr_rd_stop",  op_read,  addr_ttmr,  32'h0,        32'hb000_000a);
endtask

`endif

//--- testbench/tb_or1200_spr_periph_top.sv
`timescale 1ns/10ps
`include "or1200_settings.svh"

module tb_or1200_spr_periph_top;

	// Table operations
	localparam int op_write = 0;
	localparam int op_read  = 1;
	localparam int op_ints  = 2;
	localparam int op_wait  = 3;
	localparam int op_idle  = 4;

	localparam logic [15:0] addr_picmr = {`OR1200_SPR_GROUP_PIC, `OR1200_PIC_OFS_PICMR};
	localparam logic [15:0] addr_picsr = {`OR1200_SPR_GROUP_PIC, `OR1200_PIC_OFS_PICSR};
	localparam logic [15:0] addr_ttmr  = {`OR1200_SPR_GROUP_TT, `OR1200_TT_OFS_TTMR};
	localparam logic [15:0] addr_ttcr  = {`OR1200_SPR_GROUP_TT, `OR1200_TT_OFS_TTCR};

	// Line picked by a wait entry
	localparam logic [15:0] line_int  = 16'd0;
	localparam logic [15:0] line_tick = 16'd1;

	logic				clk;
	logic				rst_n;
	logic				spr_stb;
	logic				spr_we;
	logic [15:0]			spr_addr;
	logic [31:0]			spr_wdat;
	logic [31:0]			spr_rdat;
	logic				spr_ack;
	logic [`OR1200_PIC_INTS-1:0]	pic_ints;
	logic				sig_int;
	logic				sig_tick;

	string		case_name[$];
	int		case_op[$];
	logic [15:0]	case_addr[$];
	logic [31:0]	case_data[$];
	logic [31:0]	case_exp[$];

	integer		seed;
	logic [31:0]	rnd_picmr;
	logic [31:0]	rnd_ttmr;
	logic [31:0]	rnd_ttcr;

	int	cycle_cnt = 0;
	int	cycle_limit = 0;
	int	stb_cnt = 0;
	int	ack_cnt = 0;

	or1200_spr_periph_top or1200_spr_periph_top_inst (
		.clk_i		(clk),
		.rst_n_i	(rst_n),
		.spr_stb_i	(spr_stb),
		.spr_we_i	(spr_we),
		.spr_addr_i	(spr_addr),
		.spr_dat_i	(spr_wdat),
		.spr_dat_o	(spr_rdat),
		.spr_ack_o	(spr_ack),
		.pic_ints_i	(pic_ints),
		.sig_int_o	(sig_int),
		.sig_tick_o	(sig_tick)
	);

	always #4 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Error: %s expected %h actual %h", name, exp, act);
		$display("Result: FAILED");
		$fatal(1, "Value check failed in %s", name);
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic add_case(input string name, input int op, input logic [15:0] addr,
			input logic [31:0] dat, input logic [31:0] exp);
		case_name.push_back(name);
		case_op.push_back(op);
		case_addr.push_back(addr);
		case_data.push_back(dat);
		case_exp.push_back(exp);
	endtask

`include "tb_spr_cases.svh"

	// One strobe cycle, then the single ack and its data
	task automatic run_access(input string name, input logic we, input logic [15:0] addr,
			input logic [31:0] dat, input logic [31:0] exp);
		int waited;
		waited = 0;
		@(posedge clk);
		spr_stb  <= 1'b1;
		spr_we   <= we;
		spr_addr <= addr;
		spr_wdat <= dat;
		@(posedge clk);
		spr_stb <= 1'b0;
		spr_we  <= 1'b0;
		@(negedge clk);
		while (!spr_ack && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		assert (spr_ack) else report_problem({name, ": the access was never acknowledged"});
		assert (waited == 0) else report_mismatch({name, " ack delay"}, 32'd0, waited);
		assert (spr_rdat == exp) else report_mismatch(name, exp, spr_rdat);
		@(negedge clk);
		assert (!spr_ack) else report_problem({name, ": acknowledge stayed high too long"});
	endtask

	task automatic apply_ints(input logic [31:0] dat);
		@(posedge clk);
		pic_ints <= dat[`OR1200_PIC_INTS-1:0];
	endtask

	task automatic wait_line(input string name, input logic [15:0] sel, input int bound,
			input logic lvl);
		int waited;
		logic level;
		waited = 0;
		@(negedge clk);
		level = (sel == line_int) ? sig_int : sig_tick;
		while (level !== lvl && waited < bound) begin
			@(negedge clk);
			waited++;
			level = (sel == line_int) ? sig_int : sig_tick;
		end
		assert (level === lvl) else report_mismatch(name, {31'b0, lvl}, {31'b0, level});
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit)
			report_problem("Timeout: the table did not finish within the cycle limit");
	end

	// Strobes and acks must pair up over the whole run
	always @(negedge clk) begin
		if (rst_n) begin
			if (spr_stb)
				stb_cnt++;
			if (spr_ack)
				ack_cnt++;
		end
	end

	initial begin
		int total;
		clk = 1'b0;
		rst_n = 1'b0;
		spr_stb = 1'b0;
		spr_we = 1'b0;
		spr_addr = '0;
		spr_wdat = '0;
		pic_ints = '0;
		seed = 28251;
		rnd_picmr = $random(seed);
		// Mode 0 so the counter holds still
		rnd_ttmr = $random(seed) & 32'h3fff_ffff;
		rnd_ttcr = $random(seed);
		load_cases();

		total = 0;
		for (int i = 0; i < case_op.size(); i++) begin
			if (case_op[i] == op_wait || case_op[i] == op_idle)
				total += int'(case_data[i]);
			else
				total += 3;
		end
		cycle_limit = 2 * total + 20;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (spr_rdat == '0) else report_mismatch("reset_dat", 32'h0, spr_rdat);
		assert (!spr_ack) else report_mismatch("reset_ack", 32'h0, {31'b0, spr_ack});
		assert (!sig_int) else report_mismatch("reset_int", 32'h0, {31'b0, sig_int});
		assert (!sig_tick) else report_mismatch("reset_tick", 32'h0, {31'b0, sig_tick});

		for (int i = 0; i < case_op.size(); i++) begin
			case (case_op[i])
				op_write: run_access(case_name[i], 1'b1, case_addr[i], case_data[i], case_exp[i]);
				op_read:  run_access(case_name[i], 1'b0, case_addr[i], 32'h0, case_exp[i]);
				op_ints:  apply_ints(case_data[i]);
				op_wait:  wait_line(case_name[i], case_addr[i], int'(case_data[i]), case_exp[i][0]);
				default:  idle_cycles(int'(case_data[i]));
			endcase
		end

		repeat (2) @(negedge clk);
		assert (ack_cnt == stb_cnt) else report_mismatch("ack_count", stb_cnt, ack_cnt);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+src
+incdir+testbench
src/spr_pkg.sv
src/spr_decode.sv
src/pic_unit.sv
src/tick_timer.sv
src/spr_result.sv
src/or1200_spr_periph_top.sv
testbench/tb_or1200_spr_periph_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SPR peripheral testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

top=tb_or1200_spr_periph_top

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found in PATH"
	exit 1
fi

# Compile
verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Build failed with status $status"
	exit "$status"
fi

# Run, a fatal in the testbench gives a nonzero status
./obj_dir/V"$top"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
